//--- vlog.f
rtl/dcache_cfg_pkg.sv
rtl/dcache_bus_pkg.sv
rtl/dcache_store.sv
rtl/dcache_way_select.sv
rtl/dcache_beat_counter.sv
rtl/dcache_ctrl_fsm.sv
rtl/dcache_top.sv
test/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - rtl/dcache_cfg_pkg.sv
  - rtl/dcache_bus_pkg.sv
  - rtl/dcache_store.sv
  - rtl/dcache_way_select.sv
  - rtl/dcache_beat_counter.sv
  - rtl/dcache_ctrl_fsm.sv
  - rtl/dcache_top.sv
  - target: test
    files:
      - test/dcache_tb.sv

//--- test/dcache_tb.sv
/*
 Data cache testbench
 Burst memory model with optional back-pressure, a reference copy of
 memory as the core sees it, and directed tests on the core port
*/
`timescale 1ns/1ns

module dcache_tb;

   localparam int MEM_WORDS   = 1 << (dcache_cfg_pkg::ADDR_W - 2);
   localparam int NUM_TESTS   = 7;
   localparam int MAX_REQS    = 6;
   // Worst case for one request under back-pressure, writeback plus refill
   localparam int MISS_CYCLES = 400;
   localparam int LIMIT       = dcache_cfg_pkg::SETS + NUM_TESTS * MAX_REQS * MISS_CYCLES;
   localparam dcache_cfg_pkg::addr_t LINE_MASK =
      dcache_cfg_pkg::addr_t'(dcache_cfg_pkg::LINE_WORDS * dcache_cfg_pkg::WORD_BYTES - 1);

   logic                  clk;
   logic                  i_arst_n;
   logic                  i_req;
   logic                  i_we;
   dcache_cfg_pkg::addr_t i_addr;
   dcache_bus_pkg::word_t i_wdata;
   dcache_bus_pkg::strb_t i_wstrb;
   logic                  o_stall;
   logic                  o_rsp_valid;
   dcache_bus_pkg::word_t o_rdata;
   logic                  o_mem_cmd_valid;
   logic                  o_mem_cmd_write;
   dcache_cfg_pkg::addr_t o_mem_cmd_addr;
   logic                  i_mem_cmd_ready;
   logic                  o_mem_wvalid;
   dcache_bus_pkg::word_t o_mem_wdata;
   logic                  o_mem_wlast;
   logic                  i_mem_wready;
   logic                  i_mem_rvalid;
   dcache_bus_pkg::word_t i_mem_rdata;
   logic                  i_mem_rlast;
   logic                  o_mem_rready;
   logic                  i_mem_bvalid;
   logic                  o_mem_bready;

   dcache_bus_pkg::word_t mem_words [MEM_WORDS];
   dcache_bus_pkg::word_t ref_mem [MEM_WORDS];
   dcache_bus_pkg::word_t exp_q [$];
   bit                    read_q [$];
   int                    acc_q [$];
   int                    lat_q [$];
   dcache_bus_pkg::word_t exp_word;
   bit                    exp_read;
   int                    errors;
   int                    tests_run;
   int                    cycles;
   int                    wb_count;
   bit                    bp_on;
   logic [15:0]           lfsr;

   // Memory model state, sampled handshakes first
   logic                  s_cmd_hs;
   logic                  s_w_hs;
   logic                  s_r_hs;
   logic                  s_b_hs;
   logic                  s_cmd_write;
   dcache_cfg_pkg::addr_t s_cmd_addr;
   dcache_bus_pkg::word_t s_wdata;
   logic                  s_wlast;
   bit                    wr_pending;
   bit                    b_pending;
   bit                    rd_active;
   int                    wr_word;
   int                    rd_word;
   int                    wbeat;
   int                    rbeat;

   dcache_top UUT (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_req           (i_req),
      .i_we            (i_we),
      .i_addr          (i_addr),
      .i_wdata         (i_wdata),
      .i_wstrb         (i_wstrb),
      .o_stall         (o_stall),
      .o_rsp_valid     (o_rsp_valid),
      .o_rdata         (o_rdata),
      .o_mem_cmd_valid (o_mem_cmd_valid),
      .o_mem_cmd_write (o_mem_cmd_write),
      .o_mem_cmd_addr  (o_mem_cmd_addr),
      .i_mem_cmd_ready (i_mem_cmd_ready),
      .o_mem_wvalid    (o_mem_wvalid),
      .o_mem_wdata     (o_mem_wdata),
      .o_mem_wlast     (o_mem_wlast),
      .i_mem_wready    (i_mem_wready),
      .i_mem_rvalid    (i_mem_rvalid),
      .i_mem_rdata     (i_mem_rdata),
      .i_mem_rlast     (i_mem_rlast),
      .o_mem_rready    (o_mem_rready),
      .i_mem_bvalid    (i_mem_bvalid),
      .o_mem_bready    (o_mem_bready)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT)
      begin
         $display("Timeout after %0d cycles, the cache stopped answering", cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // Initial memory word, spread over the whole word address
   function dcache_bus_pkg::word_t init_word(input int unsigned widx);
      return dcache_bus_pkg::word_t'(32'hC3A50000 ^ (widx * 32'h00010007));
   endfunction

   function dcache_bus_pkg::word_t merge_bytes(input dcache_bus_pkg::word_t old,
                                               input dcache_bus_pkg::word_t data,
                                               input dcache_bus_pkg::strb_t strb);
      dcache_bus_pkg::word_t res;
      res = old;
      for (int b = 0; b < dcache_cfg_pkg::WORD_BYTES; b++)
      begin
         if (strb[b])
            res[8*b +: 8] = data[8*b +: 8];
      end
      return res;
   endfunction

   function dcache_cfg_pkg::addr_t line_addr(input dcache_cfg_pkg::tag_t tag,
                                             input dcache_cfg_pkg::index_t set,
                                             input dcache_cfg_pkg::beat_t beat);
      return {tag, set, beat, 2'b00};
   endfunction

   // Galois LFSR, one step per bit
   function logic lfsr_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out)
         lfsr = lfsr ^ 16'hB400;
      return out;
   endfunction

   function logic grant();
      if (!bp_on)
         return 1'b1;
      return lfsr_bit();
   endfunction

   task check_word(input dcache_bus_pkg::word_t got, input dcache_bus_pkg::word_t exp,
                   input string what);
      if (got !== exp)
      begin
         errors++;
         $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task check_addr(input dcache_cfg_pkg::addr_t got, input dcache_cfg_pkg::addr_t exp,
                   input string what);
      if (got !== exp)
      begin
         errors++;
         $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Response monitor, responses come back in acceptance order
   always @(negedge clk)
   begin
      if (i_arst_n && o_rsp_valid)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("Response pulse at %0t with no request outstanding", $time);
         end
         else
         begin
            exp_word = exp_q.pop_front();
            exp_read = read_q.pop_front();
            if (exp_read)
               check_word(o_rdata, exp_word, "read data");
            lat_q.push_back(cycles - acc_q.pop_front());
         end
      end
   end

   // Burst memory, one command at a time
   always
   begin
      @(negedge clk);
      s_cmd_hs    = o_mem_cmd_valid && i_mem_cmd_ready;
      s_w_hs      = o_mem_wvalid && i_mem_wready;
      s_r_hs      = i_mem_rvalid && o_mem_rready;
      s_b_hs      = i_mem_bvalid && o_mem_bready;
      s_cmd_write = o_mem_cmd_write;
      s_cmd_addr  = o_mem_cmd_addr;
      s_wdata     = o_mem_wdata;
      s_wlast     = o_mem_wlast;
      @(posedge clk);
      #1;
      if (s_cmd_hs)
      begin
         check_addr(s_cmd_addr, s_cmd_addr & ~LINE_MASK, "burst address");
         if (s_cmd_write)
         begin
            wr_pending = 1'b1;
            wr_word    = int'(s_cmd_addr >> 2);
            wbeat      = 0;
         end
         else
         begin
            rd_active = 1'b1;
            rd_word   = int'(s_cmd_addr >> 2);
            rbeat     = 0;
         end
      end
      if (s_w_hs)
      begin
         // A dirty line goes out as the core last saw it
         check_word(s_wdata, ref_mem[wr_word + wbeat], "writeback data");
         if (s_wlast != (wbeat == dcache_bus_pkg::BURST_BEATS - 1))
         begin
            errors++;
            $display("Write burst at %0t has its last flag on beat %0d", $time, wbeat);
         end
         mem_words[wr_word + wbeat] = s_wdata;
         wbeat++;
         if (s_wlast)
         begin
            wr_pending = 1'b0;
            b_pending  = 1'b1;
            wb_count++;
         end
      end
      if (s_b_hs)
         i_mem_bvalid = 1'b0;
      if (b_pending && !i_mem_bvalid && grant())
      begin
         i_mem_bvalid = 1'b1;
         b_pending    = 1'b0;
      end
      if (s_r_hs)
      begin
         i_mem_rvalid = 1'b0;
         rbeat++;
         if (rbeat == dcache_bus_pkg::BURST_BEATS)
            rd_active = 1'b0;
      end
      if (rd_active && !i_mem_rvalid && grant())
      begin
         i_mem_rvalid = 1'b1;
         i_mem_rdata  = mem_words[rd_word + rbeat];
         i_mem_rlast  = (rbeat == dcache_bus_pkg::BURST_BEATS - 1);
      end
      i_mem_wready    = wr_pending && grant();
      i_mem_cmd_ready = !wr_pending && !b_pending && !i_mem_bvalid && !rd_active && grant();
   end

   // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
   task drive_req(input logic we, input dcache_cfg_pkg::addr_t addr,
                  input dcache_bus_pkg::word_t wdata, input dcache_bus_pkg::strb_t wstrb);
      int widx;
      widx    = int'(addr >> 2);
      i_req   = 1'b1;
      i_we    = we;
      i_addr  = addr;
      i_wdata = wdata;
      i_wstrb = wstrb;
      @(negedge clk);
      while (o_stall)
         @(negedge clk);
      if (we)
         ref_mem[widx] = merge_bytes(ref_mem[widx], wdata, wstrb);
      exp_q.push_back(ref_mem[widx]);
      read_q.push_back(!we);
      acc_q.push_back(cycles);
      @(posedge clk);
      #1;
      i_req = 1'b0;
      i_we  = 1'b0;
   endtask

   task wait_idle();
      while (exp_q.size() != 0)
         @(negedge clk);
      @(posedge clk);
      #1;
   endtask

   task check_hit_latency(input int first);
      for (int i = first; i < lat_q.size(); i++)
      begin
         if (lat_q[i] != 1)
         begin
            errors++;
            $display("Request %0d answered after %0d cycles, a hit takes 1", i, lat_q[i]);
         end
      end
   endtask

   task report_test(input string name, input int err0);
      tests_run++;
      if (errors == err0)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, errors - err0);
   endtask

   task test_boot_miss();
      int err0;
      int boot_cycles;
      err0        = errors;
      boot_cycles = 0;
      lat_q.delete();
      @(negedge clk);
      if (o_rsp_valid || o_mem_cmd_valid || o_mem_wvalid || o_mem_rready || o_mem_bready)
      begin
         errors++;
         $display("Cache outputs are not idle after reset");
      end
      while (o_stall)
      begin
         boot_cycles++;
         @(negedge clk);
      end
      if (boot_cycles != dcache_cfg_pkg::SETS)
      begin
         errors++;
         $display("Boot stalled %0d cycles instead of %0d", boot_cycles, dcache_cfg_pkg::SETS);
      end
      @(posedge clk);
      #1;
      drive_req(1'b0, 12'h1A4, '0, '0);
      wait_idle();
      if (lat_q.size() != 1 || lat_q[0] < 2)
      begin
         errors++;
         $display("First read of a cold line was not handled as a miss");
      end
      report_test("boot and read miss", err0);
   endtask

   task test_hit_pair();
      int err0;
      err0 = errors;
      lat_q.delete();
      drive_req(1'b0, 12'h1A8, '0, '0);
      drive_req(1'b0, 12'h1AC, '0, '0);
      wait_idle();
      check_hit_latency(0);
      report_test("back to back read hits", err0);
   endtask

   // A first read brings the line in, then write hit and read back
   task test_write_hit(input dcache_cfg_pkg::addr_t addr, input dcache_bus_pkg::word_t data,
                       input dcache_bus_pkg::strb_t strb, input string name);
      int err0;
      err0 = errors;
      lat_q.delete();
      drive_req(1'b0, addr, '0, '0);
      drive_req(1'b1, addr, data, strb);
      drive_req(1'b0, addr, '0, '0);
      wait_idle();
      check_hit_latency(1);
      report_test(name, err0);
   endtask

   task test_write_read_next();
      int err0;
      err0 = errors;
      lat_q.delete();
      drive_req(1'b1, 12'h1A0, 32'h0BADF00D, 4'hF);
      drive_req(1'b0, 12'h1A0, '0, '0);
      wait_idle();
      check_hit_latency(0);
      report_test("read right after write", err0);
   endtask

   // Three lines into one two-way set force dirty evictions
   task test_evict(input dcache_cfg_pkg::index_t set, input int tag_base,
                   input dcache_bus_pkg::word_t seed, input string name);
      int err0;
      int wb0;
      dcache_cfg_pkg::addr_t a;
      err0 = errors;
      wb0  = wb_count;
      for (int t = 0; t < 3; t++)
      begin
         a = line_addr(dcache_cfg_pkg::tag_t'(tag_base + t), set, dcache_cfg_pkg::beat_t'(t));
         drive_req(1'b1, a, seed ^ dcache_bus_pkg::word_t'(t * 32'h01010101), 4'hF);
      end
      for (int t = 0; t < 3; t++)
      begin
         a = line_addr(dcache_cfg_pkg::tag_t'(tag_base + t), set, dcache_cfg_pkg::beat_t'(t));
         drive_req(1'b0, a, '0, '0);
      end
      wait_idle();
      if (wb_count == wb0)
      begin
         errors++;
         $display("No writeback burst was seen for set %0d", set);
      end
      report_test(name, err0);
   endtask

   initial
   begin
      clk             = 1'b0;
      i_arst_n        = 1'b0;
      i_req           = 1'b0;
      i_we            = 1'b0;
      i_addr          = '0;
      i_wdata         = '0;
      i_wstrb         = '0;
      i_mem_cmd_ready = 1'b0;
      i_mem_wready    = 1'b0;
      i_mem_rvalid    = 1'b0;
      i_mem_rdata     = '0;
      i_mem_rlast     = 1'b0;
      i_mem_bvalid    = 1'b0;
      lfsr            = 16'd17;
      errors          = 0;
      tests_run       = 0;
      cycles          = 0;
      wb_count        = 0;
      bp_on           = 1'b0;
      wr_pending      = 1'b0;
      b_pending       = 1'b0;
      rd_active       = 1'b0;
      for (int w = 0; w < MEM_WORDS; w++)
      begin
         mem_words[w] = init_word(w);
         ref_mem[w]   = init_word(w);
      end
      repeat (4) @(posedge clk);
      #1;
      i_arst_n = 1'b1;
      test_boot_miss();
      test_hit_pair();
      test_write_hit(12'h1A8, 32'h11223344, 4'b0101, "strobed write hit");
      test_write_read_next();
      test_evict(4'd5, 1, 32'hA0B0C0D0, "eviction with writeback");
      // Same checks with random stalls on every memory channel
      bp_on = 1'b1;
      test_write_hit(12'h3C4, 32'h55667788, 4'b1010, "strobed write hit, back-pressure");
      test_evict(4'd9, 4, 32'h13579BDF, "eviction with writeback, back-pressure");
      $display("%0d tests run, %0d errors", tests_run, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- rtl/dcache_top.sv
/*
 Two-way set-associative write-back data cache
 Two-stage request pipeline, burst refill and writeback on a miss
*/
`timescale 1ns/1ns

module dcache_top (
   input  logic                    clk,
   input  logic                    i_arst_n,
   input  logic                    i_req,
   input  logic                    i_we,
   input  dcache_cfg_pkg::addr_t   i_addr,
   input  dcache_bus_pkg::word_t   i_wdata,
   input  dcache_bus_pkg::strb_t   i_wstrb,
   output logic                    o_stall,
   output logic                    o_rsp_valid,
   output dcache_bus_pkg::word_t   o_rdata,
   output logic                    o_mem_cmd_valid,
   output logic                    o_mem_cmd_write,
   output dcache_cfg_pkg::addr_t   o_mem_cmd_addr,
   input  logic                    i_mem_cmd_ready,
   output logic                    o_mem_wvalid,
   output dcache_bus_pkg::word_t   o_mem_wdata,
   output logic                    o_mem_wlast,
   input  logic                    i_mem_wready,
   input  logic                    i_mem_rvalid,
   input  dcache_bus_pkg::word_t   i_mem_rdata,
   input  logic                    i_mem_rlast,
   output logic                    o_mem_rready,
   input  logic                    i_mem_bvalid,
   output logic                    o_mem_bready
);

   logic                                  s2_valid;
   logic                                  s2_we;
   dcache_cfg_pkg::addr_t                 s2_addr;
   dcache_bus_pkg::word_t                 s2_wdata;
   dcache_bus_pkg::strb_t                 s2_wstrb;
   dcache_cfg_pkg::tag_t                  s2_tag;
   dcache_cfg_pkg::index_t                s2_index;
   dcache_cfg_pkg::beat_t                 s2_beat;
   dcache_cfg_pkg::index_t                req_index;
   dcache_cfg_pkg::beat_t                 req_beat;
   dcache_cfg_pkg::index_t                cnt_count;
   dcache_cfg_pkg::beat_t                 cnt_beat;
   logic                                  cnt_wrap;
   logic                                  boot;
   logic                                  writeback;
   logic                                  refill;
   logic                                  replay;
   logic                                  cnt_clear;
   logic                                  cnt_step;
   logic                                  victim_advance;
   dcache_cfg_pkg::way_vec_t              hit_vec;
   dcache_cfg_pkg::way_vec_t              victim;
   logic                                  hit;
   logic                                  victim_dirty;
   logic                                  hit_write;
   logic                                  wb_read;
   dcache_cfg_pkg::tag_entry_t            tag_rdata [dcache_cfg_pkg::WAYS];
   dcache_cfg_pkg::tag_entry_t            tag_wdata;
   dcache_cfg_pkg::index_t                tag_raddr;
   dcache_cfg_pkg::index_t                tag_waddr;
   dcache_cfg_pkg::way_vec_t              tag_we;
   logic                                  tag_re;
   dcache_bus_pkg::word_t                 data_rdata [dcache_cfg_pkg::WAYS];
   dcache_bus_pkg::word_t                 data_wdata;
   dcache_bus_pkg::word_t                 hit_word;
   dcache_bus_pkg::word_t                 merged;
   logic [dcache_cfg_pkg::INDEX_W+dcache_cfg_pkg::OFFSET_W-1:0] data_raddr;
   logic [dcache_cfg_pkg::INDEX_W+dcache_cfg_pkg::OFFSET_W-1:0] data_waddr;
   dcache_cfg_pkg::way_vec_t              data_we;
   logic                                  data_re;
   dcache_cfg_pkg::tag_t                  victim_tag;

   // Address fields of the incoming and the held request
   assign req_index = i_addr[dcache_cfg_pkg::ADDR_W-dcache_cfg_pkg::TAG_W-1 -:
                             dcache_cfg_pkg::INDEX_W];
   assign req_beat  = i_addr[dcache_cfg_pkg::ADDR_W-dcache_cfg_pkg::TAG_W-
                             dcache_cfg_pkg::INDEX_W-1 -: dcache_cfg_pkg::OFFSET_W];
   assign s2_tag    = s2_addr[dcache_cfg_pkg::ADDR_W-1 -: dcache_cfg_pkg::TAG_W];
   assign s2_index  = s2_addr[dcache_cfg_pkg::ADDR_W-dcache_cfg_pkg::TAG_W-1 -:
                              dcache_cfg_pkg::INDEX_W];
   assign s2_beat   = s2_addr[dcache_cfg_pkg::ADDR_W-dcache_cfg_pkg::TAG_W-
                              dcache_cfg_pkg::INDEX_W-1 -: dcache_cfg_pkg::OFFSET_W];
   assign cnt_beat  = cnt_count[$clog2(dcache_bus_pkg::BURST_BEATS)-1:0];

   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
         s2_valid <= 1'b0;
      else if (!o_stall)
         s2_valid <= i_req;
   end

   always_ff @(posedge clk)
   begin
      if (!o_stall && i_req)
      begin
         s2_we    <= i_we;
         s2_addr  <= i_addr;
         s2_wdata <= i_wdata;
         s2_wstrb <= i_wstrb;
      end
   end

   assign hit_write = s2_valid && s2_we && !o_stall;
   assign wb_read   = cnt_step && !refill && !boot;

   // Tag store ports
   assign tag_re    = !o_stall || replay;
   assign tag_raddr = replay ? s2_index : req_index;
   assign tag_waddr = boot ? cnt_count : s2_index;
   assign tag_we    = boot ? '1 : ((hit_write ? hit_vec : '0) | (victim_advance ? victim : '0));

   always_comb
   begin
      tag_wdata.valid = !boot;
      tag_wdata.dirty = hit_write;
      tag_wdata.tag   = s2_tag;
   end

   // Data store ports
   assign data_re = !o_stall || replay || wb_read;

   always_comb
   begin
      if (wb_read)
         data_raddr = {s2_index, cnt_beat};
      else if (replay)
         data_raddr = {s2_index, s2_beat};
      else
         data_raddr = {req_index, req_beat};
   end

   assign data_waddr = {s2_index, refill ? cnt_beat : s2_beat};
   assign data_we    = (hit_write ? hit_vec : '0) |
                       ((refill && i_mem_rvalid) ? victim : '0);

   assign hit_word = hit_vec[1] ? data_rdata[1] : data_rdata[0];

   // Byte merge of a write hit into the stored word
   always_comb
   begin
      merged = hit_word;
      for (int b = 0; b < dcache_cfg_pkg::WORD_BYTES; b++)
      begin
         if (s2_wstrb[b])
            merged[8*b +: 8] = s2_wdata[8*b +: 8];
      end
   end

   assign data_wdata = refill ? i_mem_rdata : merged;

   for (genvar w = 0; w < dcache_cfg_pkg::WAYS; w++)
   begin : g_way
      dcache_store #(
         .T     (dcache_cfg_pkg::tag_entry_t),
         .DEPTH (dcache_cfg_pkg::SETS)
      ) u_tag_store (
         .clk     (clk),
         .i_re    (tag_re),
         .i_raddr (tag_raddr),
         .i_we    (tag_we[w]),
         .i_waddr (tag_waddr),
         .i_wdata (tag_wdata),
         .o_rdata (tag_rdata[w])
      );

      dcache_store #(
         .T     (dcache_bus_pkg::word_t),
         .DEPTH (dcache_cfg_pkg::SETS * dcache_cfg_pkg::LINE_WORDS)
      ) u_data_store (
         .clk     (clk),
         .i_re    (data_re),
         .i_raddr (data_raddr),
         .i_we    (data_we[w]),
         .i_waddr (data_waddr),
         .i_wdata (data_wdata),
         .o_rdata (data_rdata[w])
      );
   end

   dcache_way_select u_way_select (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_entry0       (tag_rdata[0]),
      .i_entry1       (tag_rdata[1]),
      .i_tag          (s2_tag),
      .i_advance      (victim_advance),
      .o_hit_vec      (hit_vec),
      .o_hit          (hit),
      .o_victim       (victim),
      .o_victim_dirty (victim_dirty)
   );

   dcache_beat_counter u_beat_counter (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_boot   (boot),
      .i_clear  (cnt_clear),
      .i_step   (cnt_step),
      .o_count  (cnt_count),
      .o_wrap   (cnt_wrap)
   );

   dcache_ctrl_fsm u_ctrl_fsm (
      .clk              (clk),
      .i_arst_n         (i_arst_n),
      .i_s2_valid       (s2_valid),
      .i_hit            (hit),
      .i_victim_dirty   (victim_dirty),
      .i_wrap           (cnt_wrap),
      .i_mem_cmd_ready  (i_mem_cmd_ready),
      .i_mem_wready     (i_mem_wready),
      .i_mem_rvalid     (i_mem_rvalid),
      .i_mem_rlast      (i_mem_rlast),
      .i_mem_bvalid     (i_mem_bvalid),
      .o_stall          (o_stall),
      .o_boot           (boot),
      .o_writeback      (writeback),
      .o_refill         (refill),
      .o_replay         (replay),
      .o_cnt_clear      (cnt_clear),
      .o_cnt_step       (cnt_step),
      .o_victim_advance (victim_advance),
      .o_mem_cmd_valid  (o_mem_cmd_valid),
      .o_mem_cmd_write  (o_mem_cmd_write),
      .o_mem_wvalid     (o_mem_wvalid),
      .o_mem_wlast      (o_mem_wlast),
      .o_mem_rready     (o_mem_rready),
      .o_mem_bready     (o_mem_bready)
   );

   assign o_rsp_valid = s2_valid && !o_stall;
   assign o_rdata     = hit_word;

   // Victim line goes out while writing back, the request line otherwise
   assign victim_tag     = victim[1] ? tag_rdata[1].tag : tag_rdata[0].tag;
   assign o_mem_cmd_addr = {o_mem_cmd_write ? victim_tag : s2_tag, s2_index,
                            {(dcache_cfg_pkg::ADDR_W-dcache_cfg_pkg::TAG_W-
                              dcache_cfg_pkg::INDEX_W){1'b0}}};
   assign o_mem_wdata    = (writeback && victim[1]) ? data_rdata[1] : data_rdata[0];

endmodule

//--- rtl/dcache_ctrl_fsm.sv
/*
 Cache controller
 Boot sweep, miss handling with writeback and refill, replay of
 the held request, and the memory bus handshakes
*/
`timescale 1ns/1ns

module dcache_ctrl_fsm (
   input  logic clk,
   input  logic i_arst_n,
   input  logic i_s2_valid,
   input  logic i_hit,
   input  logic i_victim_dirty,
   input  logic i_wrap,
   input  logic i_mem_cmd_ready,
   input  logic i_mem_wready,
   input  logic i_mem_rvalid,
   input  logic i_mem_rlast,
   input  logic i_mem_bvalid,
   output logic o_stall,
   output logic o_boot,
   output logic o_writeback,
   output logic o_refill,
   output logic o_replay,
   output logic o_cnt_clear,
   output logic o_cnt_step,
   output logic o_victim_advance,
   output logic o_mem_cmd_valid,
   output logic o_mem_cmd_write,
   output logic o_mem_wvalid,
   output logic o_mem_wlast,
   output logic o_mem_rready,
   output logic o_mem_bready
);

   typedef enum logic [2:0] {
      S_BOOT,
      S_IDLE,
      S_WRITEBACK,
      S_REFILL,
      S_REPLAY
   } state_t;

   state_t state_q;
   state_t state_d;
   logic   miss;
   logic   wb_start;
   logic   cmd_set;
   logic   cmd_write_d;
   logic   w_hs;
   logic   r_hs;
   logic   b_hs;
   logic   cmd_valid_q;
   logic   cmd_write_q;
   logic   wvalid_q;
   logic   wlast_q;

   assign miss     = i_s2_valid && !i_hit;
   assign wb_start = (state_q == S_IDLE) && miss && i_victim_dirty;
   assign w_hs     = wvalid_q && i_mem_wready;
   assign r_hs     = i_mem_rvalid && o_mem_rready;
   assign b_hs     = i_mem_bvalid && o_mem_bready;

   always_comb
   begin
      state_d     = state_q;
      cmd_set     = 1'b0;
      cmd_write_d = 1'b0;
      case (state_q)
         S_BOOT:
            if (i_wrap)
               state_d = S_IDLE;
         S_IDLE:
            if (miss)
            begin
               cmd_set     = 1'b1;
               cmd_write_d = i_victim_dirty;
               state_d     = i_victim_dirty ? S_WRITEBACK : S_REFILL;
            end
         S_WRITEBACK:
            if (b_hs)
            begin
               cmd_set = 1'b1;
               state_d = S_REFILL;
            end
         S_REFILL:
            if (r_hs && i_mem_rlast)
               state_d = S_REPLAY;
         default:
            state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         state_q     <= S_BOOT;
         cmd_valid_q <= 1'b0;
         cmd_write_q <= 1'b0;
         wvalid_q    <= 1'b0;
         wlast_q     <= 1'b0;
      end
      else
      begin
         state_q     <= state_d;
         cmd_valid_q <= cmd_set || (cmd_valid_q && !i_mem_cmd_ready);
         if (cmd_set)
            cmd_write_q <= cmd_write_d;
         // Data of beat 0 is read in the miss cycle, valid from the next
         if (wb_start)
            wvalid_q <= 1'b1;
         else if (w_hs && wlast_q)
            wvalid_q <= 1'b0;
         if ((state_q == S_WRITEBACK) && o_cnt_step && i_wrap)
            wlast_q <= 1'b1;
         else if (w_hs && wlast_q)
            wlast_q <= 1'b0;
      end
   end

   assign o_stall     = (state_q != S_IDLE) || miss;
   assign o_boot      = (state_q == S_BOOT);
   assign o_writeback = (state_q == S_WRITEBACK);
   assign o_refill    = (state_q == S_REFILL);
   assign o_replay    = (state_q == S_REPLAY);

   // Writeback reads run one word ahead of the bus
   assign o_cnt_step = o_boot || wb_start || r_hs || (o_writeback && w_hs && !wlast_q);
   assign o_cnt_clear      = (state_q == S_IDLE) && !wb_start;
   assign o_victim_advance = r_hs && i_mem_rlast;

   assign o_mem_cmd_valid = cmd_valid_q;
   assign o_mem_cmd_write = cmd_write_q;
   assign o_mem_wvalid    = wvalid_q;
   assign o_mem_wlast     = wlast_q;
   assign o_mem_rready    = o_refill;
   assign o_mem_bready    = o_writeback;

   a_cmd_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_mem_cmd_valid && !i_mem_cmd_ready |=> o_mem_cmd_valid && $stable(o_mem_cmd_write));

   a_w_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_mem_wvalid && !i_mem_wready |=> o_mem_wvalid && $stable(o_mem_wlast));

endmodule

//--- rtl/dcache_beat_counter.sv
/*
 Sweep and beat counter
 Walks all sets during boot, otherwise the words of one line
*/
`timescale 1ns/1ns

module dcache_beat_counter (
   input  logic                    clk,
   input  logic                    i_arst_n,
   input  logic                    i_boot,
   input  logic                    i_clear,
   input  logic                    i_step,
   output dcache_cfg_pkg::index_t  o_count,
   output logic                    o_wrap
);

   dcache_cfg_pkg::index_t last;

   // Last value before returning to zero
   assign last = i_boot ? dcache_cfg_pkg::index_t'(dcache_cfg_pkg::SETS - 1)
                        : dcache_cfg_pkg::index_t'(dcache_cfg_pkg::LINE_WORDS - 1);

   assign o_wrap = i_step && !i_clear && (o_count == last);

   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
         o_count <= '0;
      else if (i_clear)
         o_count <= '0;
      else if (i_step)
      begin
         if (o_wrap)
            o_count <= '0;
         else
            o_count <= o_count + 1'b1;
      end
   end

endmodule

//--- rtl/dcache_way_select.sv
/*
 Way selection
 Tag compare for both ways and the round-robin victim pointer
*/
`timescale 1ns/1ns

module dcache_way_select (
   input  logic                          clk,
   input  logic                          i_arst_n,
   input  dcache_cfg_pkg::tag_entry_t    i_entry0,
   input  dcache_cfg_pkg::tag_entry_t    i_entry1,
   input  dcache_cfg_pkg::tag_t          i_tag,
   input  logic                          i_advance,
   output dcache_cfg_pkg::way_vec_t      o_hit_vec,
   output logic                          o_hit,
   output dcache_cfg_pkg::way_vec_t      o_victim,
   output logic                          o_victim_dirty
);

   dcache_cfg_pkg::way_vec_t victim_q;
   dcache_cfg_pkg::way_vec_t line_dirty;

   assign o_hit_vec[0] = i_entry0.valid && (i_entry0.tag == i_tag);
   assign o_hit_vec[1] = i_entry1.valid && (i_entry1.tag == i_tag);
   assign o_hit        = |o_hit_vec;

   // Only a valid line can need a writeback
   assign line_dirty[0] = i_entry0.valid && i_entry0.dirty;
   assign line_dirty[1] = i_entry1.valid && i_entry1.dirty;

   assign o_victim       = victim_q;
   assign o_victim_dirty = |(victim_q & line_dirty);

   // One-hot pointer, rotates once per completed refill
   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
         victim_q <= dcache_cfg_pkg::way_vec_t'(1);
      else if (i_advance)
         victim_q <= {victim_q[dcache_cfg_pkg::WAYS-2:0], victim_q[dcache_cfg_pkg::WAYS-1]};
   end

   a_hit_onehot: assert property (@(posedge clk) disable iff (!i_arst_n)
      $onehot0(o_hit_vec));

endmodule

//--- rtl/dcache_store.sv
/*
 Cache storage array
 One read and one write port, registered read, write-first on
 an address collision
*/
`timescale 1ns/1ns

module dcache_store #(
   parameter type T     = logic [31:0],
   parameter int  DEPTH = 16
) (
   input  logic                     clk,
   input  logic                     i_re,
   input  logic [$clog2(DEPTH)-1:0] i_raddr,
   input  logic                     i_we,
   input  logic [$clog2(DEPTH)-1:0] i_waddr,
   input  T                         i_wdata,
   output T                         o_rdata
);

   T mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (i_we)
         mem[i_waddr] <= i_wdata;
   end

   // Output holds while no read is issued
   always_ff @(posedge clk)
   begin
      if (i_re)
      begin
         if (i_we && (i_waddr == i_raddr))
            o_rdata <= i_wdata;
         else
            o_rdata <= mem[i_raddr];
      end
   end

   a_waddr_known: assert property (@(posedge clk) i_we |-> !$isunknown(i_waddr));

endmodule

//--- rtl/dcache_bus_pkg.sv
/*
 Memory bus definitions
 One word per beat, one line per burst
*/
package dcache_bus_pkg;

   localparam int WORD_W = 32;

   typedef logic [WORD_W-1:0]   word_t;
   typedef logic [WORD_W/8-1:0] strb_t;

   // Beats in a refill or writeback burst
   localparam int BURST_BEATS = 4;

endpackage

//--- rtl/dcache_cfg_pkg.sv
/*
 Data cache geometry
 Line layout, address fields and the tag store entry format
*/
package dcache_cfg_pkg;

   localparam int ADDR_W     = 12;
   localparam int WORD_BYTES = 4;
   localparam int LINE_WORDS = 4;
   localparam int SETS       = 16;
   localparam int WAYS       = 2;

   // Address fields, from the top: tag, index, word offset, byte offset
   localparam int OFFSET_W = $clog2(LINE_WORDS);
   localparam int INDEX_W  = $clog2(SETS);
   localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W - $clog2(WORD_BYTES);

   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] beat_t;
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [WAYS-1:0]     way_vec_t;

   // One entry per set and way
   typedef struct packed {
      logic valid;
      logic dirty;
      tag_t tag;
   } tag_entry_t;

endpackage
